//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module executeUnitTb
	./obj_dir/VexecuteUnitTb | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/definitions.sv
package definitions;

    // datapath width
    localparam int XLEN        = 32;

    // issue to done, in cycles
    localparam int MUL_LATENCY = 2;   // ALU results are delayed to match
    localparam int DIV_LATENCY = 34;  // load, 32 steps, sign fix

    typedef enum logic {
        LOW  = 1'b0,
        HIGH = 1'b1
    } flag_t;

    // instruction class from the control unit
    typedef enum logic [1:0] {
        TYPE_R  = 2'd0,
        TYPE_I  = 2'd1,
        DEF_ADD = 2'd2,
        PASS_S1 = 2'd3
    } aluOp_t;

    typedef enum logic [4:0] {
        ADD    = 5'd0,
        SUB    = 5'd1,
        SLL    = 5'd2,
        SLT    = 5'd3,
        SLTU   = 5'd4,
        XOR    = 5'd5,
        SRL    = 5'd6,
        SRA    = 5'd7,
        OR     = 5'd8,
        AND    = 5'd9,
        FWD    = 5'd10,  // pass operand A through
        // M extension, multiplier
        MUL    = 5'd11,
        MULH   = 5'd12,
        MULHSU = 5'd13,
        MULHU  = 5'd14,
        // M extension, divider
        DIV    = 5'd15,
        DIVU   = 5'd16,
        REM    = 5'd17,
        REMU   = 5'd18
    } aluOperation_t;

    // same 32 bits read as R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
    } instrWord_u;

endpackage

//--- muldiv/divider.sv
`timescale 1ns/1ps

module divider (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            start,
    input  definitions::aluOperation_t      opSel,
    input  logic [definitions::XLEN-1:0]    dividend,
    input  logic [definitions::XLEN-1:0]    divisor,
    output logic                            busy,
    output logic                            done,
    output logic [definitions::XLEN-1:0]    quotient
);

    import definitions::*;

    logic [5:0]      count;
    logic            stepping;
    logic            fixing;
    logic            signedOp;
    logic            signA;
    logic            signB;
    logic [XLEN-1:0] magA;
    logic [XLEN-1:0] magB;
    logic [XLEN-1:0] remReg;   // partial remainder
    logic [XLEN-1:0] quoReg;   // dividend bits shift out as quotient bits shift in
    logic [XLEN-1:0] divReg;
    logic [XLEN:0]   shifted;
    logic            fits;
    logic            isRem;
    logic            negQuo;
    logic            negRem;

    assign signedOp = (opSel == DIV) || (opSel == REM);
    assign signA    = signedOp & dividend[XLEN-1];
    assign signB    = signedOp & divisor[XLEN-1];
    assign magA     = signA ? -dividend : dividend;  // 0x80000000 stays as its own magnitude
    assign magB     = signB ? -divisor : divisor;

    // 32 steps then one cycle for the signs
    assign stepping = busy && (count < 6'(DIV_LATENCY - 2));
    assign fixing   = busy && (count == 6'(DIV_LATENCY - 2));

    assign shifted  = {remReg, quoReg[XLEN-1]};
    assign fits     = shifted >= {1'b0, divReg};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (done) begin
                busy <= 1'b0;  // busy covers the done cycle
            end else if (busy) begin
                count <= count + 6'd1;
                if (fixing) done <= 1'b1;
            end else if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            remReg <= '0;
            quoReg <= magA;
            divReg <= magB;
            isRem  <= (opSel == REM) || (opSel == REMU);
            // no quotient negation for x/0 so it stays all ones
            negQuo <= (signA ^ signB) && (divisor != '0);
            negRem <= signA;  // remainder takes the dividend sign
        end else if (stepping) begin
            if (fits) begin
                remReg <= XLEN'(shifted - {1'b0, divReg});
                quoReg <= {quoReg[XLEN-2:0], 1'b1};
            end else begin
                remReg <= shifted[XLEN-1:0];
                quoReg <= {quoReg[XLEN-2:0], 1'b0};
            end
        end else if (fixing) begin
            // overflow lands here as magnitude 0x80000000 with no negation and rem 0
            if (isRem) quotient <= negRem ? -remReg : remReg;
            else       quotient <= negQuo ? -quoReg : quoReg;
        end
    end

    noStartWhileBusy: assert property (@(posedge clk) disable iff (!rstN) start |-> !busy)
        else $error("divider started while busy");

    // done arrives at the fixed latency and lasts one cycle
    doneTiming: assert property (@(posedge clk) disable iff (!rstN)
        start |-> ##DIV_LATENCY done ##1 !done)
        else $error("divider done missed its cycle or lasted more than one cycle");

endmodule : divider

//--- muldiv/multiplier.sv
`timescale 1ns/1ps

module multiplier (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            start,
    input  definitions::aluOperation_t      opSel,
    input  logic [definitions::XLEN-1:0]    operandA,
    input  logic [definitions::XLEN-1:0]    operandB,
    output logic                            valid,
    output logic [definitions::XLEN-1:0]    product
);

    import definitions::*;

    logic                     aSigned;
    logic                     bSigned;
    logic                     validS1;
    logic signed [XLEN:0]     aS1;     // 33 bits, one extension bit
    logic signed [XLEN:0]     bS1;
    aluOperation_t            opS1;
    aluOperation_t            opS2;
    logic signed [2*XLEN+1:0] prodS2;

    // MUL keeps only the low word, so its extension does not matter
    assign aSigned = (opSel == MULH) || (opSel == MULHSU);
    assign bSigned = (opSel == MULH);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validS1 <= 1'b0;
            valid   <= 1'b0;
        end else begin
            validS1 <= start;
            valid   <= validS1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin  // stage 1, extend operands
            aS1  <= {aSigned & operandA[XLEN-1], operandA};
            bS1  <= {bSigned & operandB[XLEN-1], operandB};
            opS1 <= opSel;
        end
        if (validS1) begin  // stage 2, full product
            prodS2 <= aS1 * bS1;
            opS2   <= opS1;
        end
    end

    assign product = (opS2 == MUL) ? prodS2[XLEN-1:0] : prodS2[2*XLEN-1:XLEN];

    validKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(valid))
        else $error("multiplier valid is unknown");

endmodule : multiplier

//--- testbench/executeUnitTb.sv
`timescale 1ns/1ps

module executeUnitTb;

    import definitions::*;

    localparam int BASE_ROUNDS = 4;   // ten base ops per round each chased by a multiply
    localparam int IMM_ROUNDS  = 4;
    localparam int MUL_ROUNDS  = 4;
    localparam int DIV_ROUNDS  = 4;
    localparam int EXTREMES    = 5;
    localparam int DEPTH       = 1024;
    localparam int TEST_COUNT  = BASE_ROUNDS * 20 + IMM_ROUNDS * 9 + 4 + MUL_ROUNDS * 4
                               + EXTREMES * EXTREMES * 4 + DIV_ROUNDS * 4 + 8 + 17;

    logic            clk;
    logic            rstN;
    logic            issue;
    aluOp_t          opClass;
    instrWord_u      instr;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] result;
    logic            done;
    flag_t           error;
    logic            busy;

    // expected results in issue order
    logic [XLEN-1:0] expResult [DEPTH];
    logic            expError  [DEPTH];
    logic            expIsDiv  [DEPTH];
    int              expDue    [DEPTH];
    int              wrPtr;
    int              rdPtr       = 0;
    int              cycleCount  = 0;
    logic            divInFlight = 1'b0;
    logic            issueDiv;
    logic            issuedAny;
    logic [31:0]     lfsrState;
    logic            pending;
    logic [XLEN-1:0] headResult;
    logic            headError;
    logic            headIsDiv;
    int              headDue;

    assign pending    = (rdPtr != wrPtr);
    assign headResult = expResult[rdPtr];
    assign headError  = expError[rdPtr];
    assign headIsDiv  = expIsDiv[rdPtr];
    assign headDue    = expDue[rdPtr];

    executeUnit u_dut (
        .clk(clk), .rstN(rstN), .issue(issue), .aluOp(opClass), .instr(instr),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .result(result), .done(done), .error(error), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [XLEN-1:0] expected,
                                  input logic [XLEN-1:0] actual);
        $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
        abortRun();
    endtask

    task automatic reportProblem(input string what);
        $display("Error at %0t: %s", $time, what);
        abortRun();
    endtask

    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    function automatic logic [31:0] randomBits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);  // one step per bit
        end
        return value;
    endfunction

    function automatic logic [31:0] rWord(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
    endfunction

    function automatic logic [31:0] iWord(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'd1, f3, 5'd3, 7'b0010011};
    endfunction

    // illegal encodings become a flagged add
    function automatic aluOperation_t decodeOp(input aluOp_t cls, input logic [6:0] f7,
                                               input logic [2:0] f3, output logic bad);
        aluOperation_t base [8];
        aluOperation_t mext [8];
        base = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
        mext = '{MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
        bad  = 1'b0;
        case (cls)
            DEF_ADD: return ADD;
            PASS_S1: return FWD;
            TYPE_R: begin
                if (f7 == 7'h00) return base[f3];
                if (f7 == 7'h01) return mext[f3];
                if (f7 == 7'h20 && f3 == 3'd0) return SUB;
                if (f7 == 7'h20 && f3 == 3'd5) return SRA;
            end
            default: begin  // I-type with the upper immediate checked for shifts only
                if (f3 == 3'd5 && f7 == 7'h20) return SRA;
                if ((f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00) return base[f3];
            end
        endcase
        bad = 1'b1;
        return ADD;
    endfunction

    function automatic logic [XLEN-1:0] compute(input aluOperation_t op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        int          sa;
        int          sb;
        logic        zeroDiv;
        logic        overflow;
        logic [31:0] sQuo;
        logic [31:0] sRem;
        logic [63:0] ssProd;
        logic [63:0] suProd;
        logic [63:0] uuProd;
        sa       = a;
        sb       = b;
        zeroDiv  = (b == 32'h0);
        overflow = (a == 32'h80000000) && (b == 32'hffffffff);
        sQuo     = 32'hffffffff;  // x/0 results
        sRem     = a;
        if (overflow) begin
            sQuo = a;
            sRem = 32'h0;
        end else if (!zeroDiv) begin
            sQuo = sa / sb;  // truncates toward zero
            sRem = sa % sb;
        end
        ssProd   = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // 64-bit wraparound keeps signs right
        suProd   = {{32{a[31]}}, a} * {32'h0, b};
        uuProd   = {32'h0, a} * {32'h0, b};
        case (op)
            ADD:    return a + b;
            SUB:    return a - b;
            SLL:    return a << b[4:0];
            SRL:    return a >> b[4:0];
            SRA:    return sa >>> b[4:0];
            SLT:    return (sa < sb) ? 32'd1 : 32'd0;
            SLTU:   return (a < b) ? 32'd1 : 32'd0;
            XOR:    return a ^ b;
            OR:     return a | b;
            AND:    return a & b;
            FWD:    return a;
            MUL:    return uuProd[31:0];
            MULH:   return ssProd[63:32];
            MULHSU: return suProd[63:32];
            MULHU:  return uuProd[63:32];
            DIV:    return sQuo;
            DIVU:   return zeroDiv ? 32'hffffffff : a / b;
            REM:    return sRem;
            REMU:   return zeroDiv ? a : a % b;
            default: return 32'h0;
        endcase
    endfunction

    // drive one op for a cycle and record its expected result and done cycle
    task automatic issueOp(input aluOp_t cls, input logic [31:0] word,
                           input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        aluOperation_t   op;
        logic            bad;
        logic            isDiv;
        logic [XLEN-1:0] opB;
        int              cycles;
        opB   = (cls == TYPE_I) ? {{20{word[31]}}, word[31:20]} : b;
        op    = decodeOp(cls, word[31:25], word[14:12], bad);
        isDiv = op inside {DIV, DIVU, REM, REMU};
        expResult[wrPtr] = compute(op, a, opB);
        expError[wrPtr]  = bad;
        expIsDiv[wrPtr]  = isDiv;
        expDue[wrPtr]    = cycleCount + (isDiv ? DIV_LATENCY : MUL_LATENCY);
        wrPtr++;
        issuedAny = 1'b1;
        opClass   = cls;
        instr     = word;
        rs1Data   = a;
        rs2Data   = b;
        issueDiv  = isDiv;
        issue     = 1'b1;
        @(posedge clk);
        #1;
        issue    = 1'b0;
        issueDiv = 1'b0;
        cycles   = 0;
        while (isDiv && busy) begin  // nothing may issue until the divider is done
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > DIV_LATENCY + 4) reportProblem("divider stayed busy too long");
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (rstN && done && pending) begin
            rdPtr <= rdPtr + 1;
            if (headIsDiv) divInFlight <= 1'b0;
        end
        if (issue && issueDiv) divInFlight <= 1'b1;
    end

    quietAfterReset: assert property (@(posedge clk) disable iff (!rstN)
        !issuedAny |-> (!done && error == LOW && !busy))
        else reportMismatch("{done,error,busy}", 0,
                            {$sampled(done), $sampled(error), $sampled(busy)});
    doneExpected: assert property (@(posedge clk) disable iff (!rstN) done |-> pending)
        else reportProblem("done raised with no operation outstanding");
    resultMatches: assert property (@(posedge clk) disable iff (!rstN) done |-> result == headResult)
        else reportMismatch("result", $sampled(headResult), $sampled(result));
    errorMatches: assert property (@(posedge clk) disable iff (!rstN) done |-> error == headError)
        else reportMismatch("error", $sampled(headError), $sampled(error));
    latencyHolds: assert property (@(posedge clk) disable iff (!rstN) done |-> cycleCount == headDue)
        else reportMismatch("done cycle", $sampled(headDue), $sampled(cycleCount));
    doneOnTime: assert property (@(posedge clk) disable iff (!rstN)
        (pending && cycleCount == headDue) |-> done)
        else reportProblem("done did not rise at the expected cycle");
    busyDuringDiv: assert property (@(posedge clk) disable iff (!rstN) divInFlight |-> busy)
        else reportMismatch("busy", 1, $sampled(busy));

    initial begin
        #((TEST_COUNT * 40 + 200) * 10);
        reportProblem("watchdog expired before the tests finished");
    end

    initial begin
        logic [XLEN-1:0] extremes [EXTREMES];
        logic [6:0]      baseF7 [10];
        logic [2:0]      baseF3 [10];
        logic [11:0]     imm;
        logic [6:0]      f7;
        int              drain;
        extremes  = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff, 32'h1};
        baseF7    = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
        baseF3    = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        lfsrState = 32'h70a3;
        wrPtr     = 0;
        issuedAny = 1'b0;
        issueDiv  = 1'b0;
        issue     = 1'b0;
        opClass   = TYPE_R;
        instr     = '0;
        rs1Data   = '0;
        rs2Data   = '0;
        rstN      = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        repeat (3) @(posedge clk);  // idle cycles with outputs low
        #1;
        for (int r = 0; r < BASE_ROUNDS; r++) begin
            for (int k = 0; k < 10; k++) begin
                issueOp(TYPE_R, rWord(baseF7[k], baseF3[k]), randomBits(32), randomBits(32));
                issueOp(TYPE_R, rWord(7'h01, 3'(randomBits(2))), randomBits(32), randomBits(32));
            end
        end
        for (int r = 0; r < IMM_ROUNDS; r++) begin
            for (int f = 0; f < 8; f++) begin
                imm = 12'(randomBits(12));
                if (f == 1 || f == 5) imm[11:5] = 7'h00;  // legal SLLI and SRLI
                issueOp(TYPE_I, iWord(imm, 3'(f)), randomBits(32), randomBits(32));
            end
            issueOp(TYPE_I, iWord({7'h20, 5'(randomBits(5))}, 3'd5), randomBits(32), 32'h0);
        end
        issueOp(TYPE_I, iWord({7'h20, 5'd3}, 3'd1), randomBits(32), 32'h0);
        issueOp(TYPE_I, iWord({7'h01, 5'd3}, 3'd1), randomBits(32), 32'h0);
        issueOp(TYPE_I, iWord({7'h01, 5'd7}, 3'd5), randomBits(32), 32'h0);
        issueOp(TYPE_I, iWord({7'h7f, 5'd7}, 3'd5), randomBits(32), 32'h0);
        for (int r = 0; r < MUL_ROUNDS; r++) begin
            for (int f = 0; f < 4; f++) begin
                issueOp(TYPE_R, rWord(7'h01, 3'(f)), randomBits(32), randomBits(32));
            end
        end
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < EXTREMES; i++) begin
                for (int j = 0; j < EXTREMES; j++) begin
                    issueOp(TYPE_R, rWord(7'h01, 3'(f)), extremes[i], extremes[j]);
                end
            end
        end
        for (int r = 0; r < DIV_ROUNDS; r++) begin
            for (int f = 4; f < 8; f++) begin
                issueOp(TYPE_R, rWord(7'h01, 3'(f)), randomBits(32), randomBits(8 + 8 * r));
            end
        end
        for (int f = 4; f < 8; f++) begin
            issueOp(TYPE_R, rWord(7'h01, 3'(f)), randomBits(32), 32'h0);
            issueOp(TYPE_R, rWord(7'h01, 3'(f)), 32'h80000000, 32'hffffffff);
        end
        for (int i = 0; i < 8; i++) begin
            f7 = 7'(randomBits(7));
            if (f7 inside {7'h00, 7'h01, 7'h20}) f7 = 7'h7f;
            issueOp(TYPE_R, rWord(f7, 3'(randomBits(3))), randomBits(32), randomBits(32));
        end
        issueOp(TYPE_R, rWord(7'h20, 3'd3), randomBits(32), randomBits(32));
        for (int i = 0; i < 4; i++) begin
            issueOp(DEF_ADD, randomBits(32), randomBits(32), randomBits(32));
            issueOp(PASS_S1, randomBits(32), randomBits(32), randomBits(32));
        end
        drain = 0;
        while (pending && drain < DIV_LATENCY + 4) begin
            @(posedge clk);
            #1;
            drain++;
        end
        repeat (2) @(posedge clk);  // catch a stray done
        #1;
        if (!pending) begin
            $display("Regression passed");
            $finish;
        end else begin
            reportProblem("operations still outstanding at the end of the run");
        end
    end

endmodule : executeUnitTb

//--- verilog.f
common/definitions.sv
verilog/aluOp.sv
verilog/alu.sv
muldiv/multiplier.sv
muldiv/divider.sv
verilog/executeUnit.sv
testbench/executeUnitTb.sv

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  definitions::aluOperation_t      opSel,
    input  logic [definitions::XLEN-1:0]    operandA,
    input  logic [definitions::XLEN-1:0]    operandB,
    output logic [definitions::XLEN-1:0]    result
);

    import definitions::*;

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = operandB[4:0];  // RV32 uses only the low five bits
    assign ltSigned   = $signed(operandA) < $signed(operandB);
    assign ltUnsigned = operandA < operandB;

    always_comb begin
        case (opSel)
            ADD : result = operandA + operandB;
            SUB : result = operandA - operandB;
            SLL : result = operandA << shamt;
            SRL : result = operandA >> shamt;
            SRA : result = $signed(operandA) >>> shamt;
            SLT : result = {{(XLEN-1){1'b0}}, ltSigned};
            SLTU: result = {{(XLEN-1){1'b0}}, ltUnsigned};
            XOR : result = operandA ^ operandB;
            OR  : result = operandA | operandB;
            AND : result = operandA & operandB;
            FWD : result = operandA;
            // mul and div results come from their own units
            default: result = '0;
        endcase
    end

endmodule : alu

//--- verilog/aluOp.sv
`timescale 1ns/1ps

module aluOp (
    input  definitions::aluOp_t        aluOp,
    input  logic [6:0]                 funct7,
    input  logic [2:0]                 funct3,
    output definitions::aluOperation_t opSel,
    output definitions::flag_t         error
);

    import definitions::*;

    // funct7 classes
    localparam logic [6:0]
        type0  = 7'd0,   // RV32I
        type1  = 7'd1,   // RV32M
        type32 = 7'd32;  // RV32I, sub and sra

    // funct3 for the base ops
    localparam logic [2:0]
        addSub = 3'd0,
        sll    = 3'd1,
        slt    = 3'd2,
        sltu   = 3'd3,
        lxor   = 3'd4,
        srlSra = 3'd5,
        lor    = 3'd6,
        land   = 3'd7;

    // funct3 for the M extension
    localparam logic [2:0]
        mul    = 3'd0,
        mulh   = 3'd1,
        mulhsu = 3'd2,
        mulhu  = 3'd3,
        div    = 3'd4,
        divu   = 3'd5,
        rem    = 3'd6,
        remu   = 3'd7;

    always_comb begin
        opSel = ADD;  // illegal encodings fall back to add
        error = LOW;
        case (aluOp)
            TYPE_R: begin
                case (funct7)
                    type0: begin
                        case (funct3)
                            addSub : opSel = ADD;
                            sll    : opSel = SLL;
                            slt    : opSel = SLT;
                            sltu   : opSel = SLTU;
                            lxor   : opSel = XOR;
                            srlSra : opSel = SRL;
                            lor    : opSel = OR;
                            land   : opSel = AND;
                        endcase
                    end
                    type32: begin
                        case (funct3)
                            addSub : opSel = SUB;
                            srlSra : opSel = SRA;
                            default: error = HIGH;
                        endcase
                    end
                    type1: begin
                        case (funct3)
                            mul    : opSel = MUL;
                            mulh   : opSel = MULH;
                            mulhsu : opSel = MULHSU;
                            mulhu  : opSel = MULHU;
                            div    : opSel = DIV;
                            divu   : opSel = DIVU;
                            rem    : opSel = REM;
                            remu   : opSel = REMU;
                        endcase
                    end
                    default: error = HIGH;
                endcase
            end
            TYPE_I: begin
                // upper immediate bits are only funct7 for the shifts
                case (funct3)
                    addSub : opSel = ADD;
                    slt    : opSel = SLT;
                    sltu   : opSel = SLTU;
                    lxor   : opSel = XOR;
                    lor    : opSel = OR;
                    land   : opSel = AND;
                    sll: begin
                        if (funct7 == type0) opSel = SLL;
                        else error = HIGH;
                    end
                    srlSra: begin
                        if (funct7 == type0) opSel = SRL;
                        else if (funct7 == type32) opSel = SRA;
                        else error = HIGH;
                    end
                endcase
            end
            DEF_ADD: opSel = ADD;
            PASS_S1: opSel = FWD;
        endcase
    end

endmodule : aluOp

//--- verilog/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            issue,
    input  definitions::aluOp_t             aluOp,
    input  definitions::instrWord_u         instr,
    input  logic [definitions::XLEN-1:0]    rs1Data,
    input  logic [definitions::XLEN-1:0]    rs2Data,
    output logic [definitions::XLEN-1:0]    result,
    output logic                            done,
    output definitions::flag_t              error,
    output logic                            busy
);

    import definitions::*;

    logic [6:0]             funct7;
    logic [2:0]             funct3;
    aluOperation_t          opSel;
    flag_t                  decodeError;
    logic [XLEN-1:0]        operandB;
    logic [XLEN-1:0]        aluResult;
    logic [XLEN-1:0]        mulProduct;
    logic [XLEN-1:0]        divResult;
    logic                   isMulOp;
    logic                   isDivOp;
    logic                   mulStart;
    logic                   divStart;
    logic                   aluStart;
    logic                   mulValid;
    logic                   divDone;
    logic [MUL_LATENCY-1:0] aluValid;
    logic [XLEN-1:0]        aluPipe [MUL_LATENCY];
    flag_t                  errPipe [MUL_LATENCY];

    assign funct7   = instr.rType.funct7;
    assign funct3   = instr.rType.funct3;
    assign operandB = (aluOp == TYPE_I) ? {{(XLEN-12){instr.iType.imm12[11]}}, instr.iType.imm12}
                                        : rs2Data;

    aluOp opDecoder (.aluOp(aluOp), .funct7(funct7), .funct3(funct3),
                     .opSel(opSel), .error(decodeError));

    alu intAlu (.opSel(opSel), .operandA(rs1Data), .operandB(operandB), .result(aluResult));

    assign isMulOp  = opSel inside {MUL, MULH, MULHSU, MULHU};
    assign isDivOp  = opSel inside {DIV, DIVU, REM, REMU};
    assign mulStart = issue && isMulOp;
    assign divStart = issue && isDivOp;
    assign aluStart = issue && !isMulOp && !isDivOp;  // illegal encodings land here too

    multiplier mulUnit (
        .clk(clk), .rstN(rstN), .start(mulStart), .opSel(opSel),
        .operandA(rs1Data), .operandB(operandB),
        .valid(mulValid), .product(mulProduct)
    );

    divider divUnit (
        .clk(clk), .rstN(rstN), .start(divStart), .opSel(opSel),
        .dividend(rs1Data), .divisor(operandB),
        .busy(busy), .done(divDone), .quotient(divResult)
    );

    // delay the ALU so it lines up with the multiplier
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aluValid <= '0;
            for (int i = 0; i < MUL_LATENCY; i++) errPipe[i] <= LOW;
        end else begin
            aluValid   <= {aluValid[MUL_LATENCY-2:0], aluStart};
            errPipe[0] <= (issue && decodeError == HIGH) ? HIGH : LOW;
            for (int i = 1; i < MUL_LATENCY; i++) errPipe[i] <= errPipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        aluPipe[0] <= aluResult;
        for (int i = 1; i < MUL_LATENCY; i++) aluPipe[i] <= aluPipe[i-1];
    end

    always_comb begin
        if (divDone)       result = divResult;
        else if (mulValid) result = mulProduct;
        else               result = aluPipe[MUL_LATENCY-1];
    end

    assign done  = divDone | mulValid | aluValid[MUL_LATENCY-1];
    assign error = errPipe[MUL_LATENCY-1];

    noIssueWhileBusy: assert property (@(posedge clk) disable iff (!rstN) issue |-> !busy)
        else $error("issue raised while divider busy");

    // a short op must not finish on the divider's done cycle
    noDoneCollision: assert property (@(posedge clk) disable iff (!rstN)
        (issue && !isDivOp) |-> ##MUL_LATENCY !divDone)
        else $error("short op completes together with divider");

    oneSourceDone: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({divDone, mulValid, aluValid[MUL_LATENCY-1]}))
        else $error("more than one unit raised done");

endmodule : executeUnit
